/* hw/dispatch_pkg.sv */
`default_nettype none

package dispatch_pkg;

    localparam int DISPATCH_WIDTH = 2;
    // two sources per slot, source k belongs to slot k/2
    localparam int NUM_SRC = 4;
    localparam int NUM_CDB = 2;
    localparam int NUM_IQ = 4;

    typedef logic [31:0] word_t;
    typedef logic [31:0] pc_t;
    typedef logic [4:0]  areg_t;
    typedef logic [5:0]  preg_t;
    typedef logic [1:0]  fu_sel_t;
    typedef logic [1:0]  iq_idx_t;

    // function-unit codes
    localparam fu_sel_t FU_ALU = 2'd0;
    localparam fu_sel_t FU_MDU = 2'd1;
    localparam fu_sel_t FU_LSU = 2'd2;

    // issue queue order
    localparam iq_idx_t IQ_ALU0 = 2'd0;
    localparam iq_idx_t IQ_ALU1 = 2'd1;
    localparam iq_idx_t IQ_MDU  = 2'd2;
    localparam iq_idx_t IQ_LSU  = 2'd3;

    // bundle from rename
    typedef struct packed {
        logic    [DISPATCH_WIDTH-1:0] valid;
        pc_t     [DISPATCH_WIDTH-1:0] pc;
        areg_t   [DISPATCH_WIDTH-1:0] areg;
        preg_t   [DISPATCH_WIDTH-1:0] preg;
        logic    [DISPATCH_WIDTH-1:0] w_reg;
        logic    [DISPATCH_WIDTH-1:0] w_mem;
        fu_sel_t [DISPATCH_WIDTH-1:0] fu;
        preg_t   [NUM_SRC-1:0]        src_preg;
        logic    [NUM_SRC-1:0]        use_imm;
        logic    [NUM_SRC-1:0]        rename_data_valid;
        word_t   [NUM_SRC-1:0]        arf_data;
        word_t   [DISPATCH_WIDTH-1:0] imm;
    } rename_bundle_t;

    typedef struct packed {
        logic  we;
        preg_t preg;
        word_t data;
    } cdb_t;

    typedef struct packed {
        logic        valid;
        pc_t         pc;
        areg_t       areg;
        preg_t       preg;
        preg_t [1:0] src_preg;
        logic        w_reg;
        logic        w_mem;
    } rob_entry_t;

    // one queue entry, whole bundle plus per-slot choose mask
    typedef struct packed {
        logic    [DISPATCH_WIDTH-1:0] choose;
        preg_t   [NUM_SRC-1:0]        src_preg;
        word_t   [NUM_SRC-1:0]        data;
        logic    [NUM_SRC-1:0]        data_valid;
        fu_sel_t [DISPATCH_WIDTH-1:0] fu;
        preg_t   [DISPATCH_WIDTH-1:0] preg;
    } issue_pkt_t;

endpackage

`default_nettype wire

/* hw/operand_select.sv */
`timescale 1ns/10ps
`default_nettype none

module operand_select
    import dispatch_pkg::*;
(
    input  rename_bundle_t        rn_bundle_i,
    input  cdb_t  [NUM_CDB-1:0]   cdb_i,
    input  word_t [NUM_SRC-1:0]   rob_data_i,
    input  logic  [NUM_SRC-1:0]   rob_complete_i,
    output word_t [NUM_SRC-1:0]   opnd_data_o,
    output logic  [NUM_SRC-1:0]   opnd_valid_o
);

    word_t [NUM_SRC-1:0] rename_word;
    word_t [NUM_SRC-1:0] cdb_word;
    logic  [NUM_SRC-1:0] cdb_hit;
    word_t [NUM_SRC-1:0] late_word;

    // value carried by rename, imm or arf
    always_comb begin
        for (int k = 0; k < NUM_SRC; k++) begin
            if (rn_bundle_i.use_imm[k]) begin
                rename_word[k] = rn_bundle_i.imm[k / 2];
            end else begin
                rename_word[k] = rn_bundle_i.arf_data[k];
            end
        end
    end

    // cdb bypass, matches from both entries ORed together
    always_comb begin
        for (int k = 0; k < NUM_SRC; k++) begin
            cdb_hit[k]  = 1'b0;
            cdb_word[k] = '0;
            for (int j = 0; j < NUM_CDB; j++) begin
                if (cdb_i[j].we && (cdb_i[j].preg == rn_bundle_i.src_preg[k])) begin
                    cdb_hit[k]  = 1'b1;
                    cdb_word[k] = cdb_word[k] | cdb_i[j].data;
                end
            end
        end
    end

    // cdb beats rob
    always_comb begin
        for (int k = 0; k < NUM_SRC; k++) begin
            if (cdb_hit[k]) begin
                late_word[k] = cdb_word[k];
            end else begin
                late_word[k] = rob_data_i[k];
            end
        end
    end

    // rename data first
    always_comb begin
        for (int k = 0; k < NUM_SRC; k++) begin
            if (rn_bundle_i.rename_data_valid[k]) begin
                opnd_data_o[k] = rename_word[k];
            end else begin
                opnd_data_o[k] = late_word[k];
            end
            opnd_valid_o[k] = rn_bundle_i.rename_data_valid[k]
                            | cdb_hit[k]
                            | rob_complete_i[k];
        end
    end

endmodule

`default_nettype wire

/* hw/dispatch_route.sv */
`timescale 1ns/10ps
`default_nettype none

module dispatch_route
    import dispatch_pkg::*;
(
    input  logic                               clk,
    input  logic                               rst_n_i,
    input  logic                               flush_i,
    input  logic                               rn_valid_i,
    input  rename_bundle_t                     rn_bundle_i,
    output logic                               rn_ready_o,
    input  word_t      [NUM_SRC-1:0]           opnd_data_i,
    input  logic       [NUM_SRC-1:0]           opnd_valid_i,
    input  logic       [NUM_IQ-1:0]            room_i,
    output logic       [DISPATCH_WIDTH-1:0]    rob_we_o,
    output rob_entry_t [DISPATCH_WIDTH-1:0]    rob_entry_o,
    output logic       [NUM_IQ-1:0]            push_valid_o,
    output issue_pkt_t [NUM_IQ-1:0]            push_pkt_o
);

    logic accept;
    logic [NUM_IQ-1:0][DISPATCH_WIDTH-1:0] choose;
    issue_pkt_t [NUM_IQ-1:0] pkt_d;
    logic [NUM_IQ-1:0] push_valid_q;
    issue_pkt_t [NUM_IQ-1:0] push_pkt_q;
    logic [DISPATCH_WIDTH-1:0][NUM_IQ-1:0] slot_taken;

    // every queue must be able to take a full bundle
    assign rn_ready_o = (&room_i) & ~flush_i;
    assign accept     = rn_valid_i & rn_ready_o;

    always_comb begin
        for (int i = 0; i < DISPATCH_WIDTH; i++) begin
            rob_we_o[i]             = accept & rn_bundle_i.valid[i];
            rob_entry_o[i].valid    = rn_bundle_i.valid[i];
            rob_entry_o[i].pc       = rn_bundle_i.pc[i];
            rob_entry_o[i].areg     = rn_bundle_i.areg[i];
            rob_entry_o[i].preg     = rn_bundle_i.preg[i];
            rob_entry_o[i].src_preg = {rn_bundle_i.src_preg[2 * i + 1],
                                       rn_bundle_i.src_preg[2 * i]};
            rob_entry_o[i].w_reg    = rn_bundle_i.w_reg[i];
            rob_entry_o[i].w_mem    = rn_bundle_i.w_mem[i];
        end
    end

    // steering: alu split by destination parity
    always_comb begin
        choose = '0;
        for (int j = 0; j < DISPATCH_WIDTH; j++) begin
            if (rn_bundle_i.valid[j]) begin
                case (rn_bundle_i.fu[j])
                    FU_ALU: begin
                        if (rn_bundle_i.preg[j][0]) begin
                            choose[IQ_ALU1][j] = 1'b1;
                        end else begin
                            choose[IQ_ALU0][j] = 1'b1;
                        end
                    end
                    FU_MDU: choose[IQ_MDU][j] = 1'b1;
                    FU_LSU: choose[IQ_LSU][j] = 1'b1;
                    default: ;
                endcase
            end
        end
    end

    always_comb begin
        for (int q = 0; q < NUM_IQ; q++) begin
            pkt_d[q].choose     = choose[q];
            pkt_d[q].src_preg   = rn_bundle_i.src_preg;
            pkt_d[q].data       = opnd_data_i;
            pkt_d[q].data_valid = opnd_valid_i;
            pkt_d[q].fu         = rn_bundle_i.fu;
            pkt_d[q].preg       = rn_bundle_i.preg;
        end
    end

    // push only toward queues with a nonzero mask
    always_ff @(posedge clk) begin
        if (!rst_n_i || flush_i) begin
            push_valid_q <= '0;
        end else if (accept) begin
            for (int q = 0; q < NUM_IQ; q++) begin
                push_valid_q[q] <= |choose[q];
            end
        end else begin
            push_valid_q <= '0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            push_pkt_q <= pkt_d;
        end
    end

    assign push_valid_o = push_valid_q;
    assign push_pkt_o   = push_pkt_q;

    always_comb begin
        for (int j = 0; j < DISPATCH_WIDTH; j++) begin
            for (int q = 0; q < NUM_IQ; q++) begin
                slot_taken[j][q] = push_valid_q[q] & push_pkt_q[q].choose[j];
            end
        end
    end

    // an accepted slot lands in exactly one queue on the next cycle
    for (genvar j = 0; j < DISPATCH_WIDTH; j++) begin : g_slot_chk
        a_slot_onehot : assert property (@(posedge clk) disable iff (!rst_n_i)
            accept && rn_bundle_i.valid[j] |=> $onehot(slot_taken[j]));
    end

    for (genvar q = 0; q < NUM_IQ; q++) begin : g_room_chk
        a_push_room : assert property (@(posedge clk) disable iff (!rst_n_i)
            push_valid_q[q] |-> $past(room_i[q]));
    end

endmodule

`default_nettype wire

/* hw/issue_queue.sv */
`timescale 1ns/10ps
`default_nettype none

module issue_queue
    import dispatch_pkg::*;
#(
    parameter int DEPTH = 8
) (
    input  logic       clk,
    input  logic       rst_n_i,
    input  logic       flush_i,
    input  logic       push_valid_i,
    input  issue_pkt_t push_pkt_i,
    output logic       room_o,
    input  logic       pop_ready_i,
    output logic       pop_valid_o,
    output issue_pkt_t pop_pkt_o
);

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);
    localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(DEPTH - 1);
    // two free entries left
    localparam logic [CNT_W-1:0] ROOM_MAX = CNT_W'(DEPTH - 2);
    localparam logic [CNT_W-1:0] CNT_FULL = CNT_W'(DEPTH);

    issue_pkt_t mem [DEPTH];
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [CNT_W-1:0] count;
    logic push;
    logic pop;

    assign pop_valid_o = (count != '0);
    assign pop_pkt_o   = mem[rd_ptr];
    assign room_o      = (count <= ROOM_MAX);

    assign push = push_valid_i;
    assign pop  = pop_valid_o & pop_ready_i;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_pkt_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i || flush_i) begin
            wr_ptr <= '0;
        end else if (push) begin
            if (wr_ptr == PTR_LAST) begin
                wr_ptr <= '0;
            end else begin
                wr_ptr <= wr_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i || flush_i) begin
            rd_ptr <= '0;
        end else if (pop) begin
            if (rd_ptr == PTR_LAST) begin
                rd_ptr <= '0;
            end else begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i || flush_i) begin
            count <= '0;
        end else begin
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // room flag upstream must keep a full queue from seeing a push
    a_no_push_full : assert property (@(posedge clk) disable iff (!rst_n_i)
        push_valid_i |-> (count != CNT_FULL));

    a_count_range : assert property (@(posedge clk) disable iff (!rst_n_i)
        count <= CNT_FULL);

endmodule

`default_nettype wire

/* hw/dispatch_top.sv */
`timescale 1ns/10ps
`default_nettype none

module dispatch_top
    import dispatch_pkg::*;
#(
    parameter int IQ_DEPTH = 8
) (
    input  logic                               clk,
    input  logic                               rst_n_i,
    input  logic                               flush_i,
    input  logic                               rn_valid_i,
    input  rename_bundle_t                     rn_bundle_i,
    output logic                               rn_ready_o,
    input  cdb_t       [NUM_CDB-1:0]           cdb_i,
    input  word_t      [NUM_SRC-1:0]           rob_data_i,
    input  logic       [NUM_SRC-1:0]           rob_complete_i,
    output logic       [DISPATCH_WIDTH-1:0]    rob_we_o,
    output rob_entry_t [DISPATCH_WIDTH-1:0]    rob_entry_o,
    output logic       [NUM_IQ-1:0]            iss_valid_o,
    input  logic       [NUM_IQ-1:0]            iss_ready_i,
    output issue_pkt_t [NUM_IQ-1:0]            iss_pkt_o
);

    word_t      [NUM_SRC-1:0] opnd_data;
    logic       [NUM_SRC-1:0] opnd_valid;
    logic       [NUM_IQ-1:0]  room;
    logic       [NUM_IQ-1:0]  push_valid;
    issue_pkt_t [NUM_IQ-1:0]  push_pkt;

    operand_select u_operand_select (
        .rn_bundle_i    (rn_bundle_i),
        .cdb_i          (cdb_i),
        .rob_data_i     (rob_data_i),
        .rob_complete_i (rob_complete_i),
        .opnd_data_o    (opnd_data),
        .opnd_valid_o   (opnd_valid)
    );

    dispatch_route u_dispatch_route (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .flush_i      (flush_i),
        .rn_valid_i   (rn_valid_i),
        .rn_bundle_i  (rn_bundle_i),
        .rn_ready_o   (rn_ready_o),
        .opnd_data_i  (opnd_data),
        .opnd_valid_i (opnd_valid),
        .room_i       (room),
        .rob_we_o     (rob_we_o),
        .rob_entry_o  (rob_entry_o),
        .push_valid_o (push_valid),
        .push_pkt_o   (push_pkt)
    );

    // even destinations
    issue_queue #(.DEPTH(IQ_DEPTH)) iq_alu0 (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .flush_i      (flush_i),
        .push_valid_i (push_valid[IQ_ALU0]),
        .push_pkt_i   (push_pkt[IQ_ALU0]),
        .room_o       (room[IQ_ALU0]),
        .pop_ready_i  (iss_ready_i[IQ_ALU0]),
        .pop_valid_o  (iss_valid_o[IQ_ALU0]),
        .pop_pkt_o    (iss_pkt_o[IQ_ALU0])
    );

    // odd destinations
    issue_queue #(.DEPTH(IQ_DEPTH)) iq_alu1 (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .flush_i      (flush_i),
        .push_valid_i (push_valid[IQ_ALU1]),
        .push_pkt_i   (push_pkt[IQ_ALU1]),
        .room_o       (room[IQ_ALU1]),
        .pop_ready_i  (iss_ready_i[IQ_ALU1]),
        .pop_valid_o  (iss_valid_o[IQ_ALU1]),
        .pop_pkt_o    (iss_pkt_o[IQ_ALU1])
    );

    issue_queue #(.DEPTH(IQ_DEPTH)) iq_mdu (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .flush_i      (flush_i),
        .push_valid_i (push_valid[IQ_MDU]),
        .push_pkt_i   (push_pkt[IQ_MDU]),
        .room_o       (room[IQ_MDU]),
        .pop_ready_i  (iss_ready_i[IQ_MDU]),
        .pop_valid_o  (iss_valid_o[IQ_MDU]),
        .pop_pkt_o    (iss_pkt_o[IQ_MDU])
    );

    issue_queue #(.DEPTH(IQ_DEPTH)) iq_lsu (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .flush_i      (flush_i),
        .push_valid_i (push_valid[IQ_LSU]),
        .push_pkt_i   (push_pkt[IQ_LSU]),
        .room_o       (room[IQ_LSU]),
        .pop_ready_i  (iss_ready_i[IQ_LSU]),
        .pop_valid_o  (iss_valid_o[IQ_LSU]),
        .pop_pkt_o    (iss_pkt_o[IQ_LSU])
    );

endmodule

`default_nettype wire

/* verification/tb_dispatch_top.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_dispatch_top
    import dispatch_pkg::*;
();

    localparam int IQ_DEPTH = 8;
    localparam int WAIT_LIMIT = 500;

    typedef cdb_t [NUM_CDB-1:0] cdb_pair_t;
    typedef word_t [NUM_SRC-1:0] rob_words_t;

    logic clk;
    logic rst_n_i;
    logic flush_i;
    logic rn_valid_i;
    rename_bundle_t rn_bundle_i;
    logic rn_ready_o;
    cdb_pair_t cdb_i;
    rob_words_t rob_data_i;
    logic [NUM_SRC-1:0] rob_complete_i;
    logic [DISPATCH_WIDTH-1:0] rob_we_o;
    rob_entry_t [DISPATCH_WIDTH-1:0] rob_entry_o;
    logic [NUM_IQ-1:0] iss_valid_o;
    logic [NUM_IQ-1:0] iss_ready_i;
    issue_pkt_t [NUM_IQ-1:0] iss_pkt_o;

    // expected packets per queue including the one waiting in the route register
    issue_pkt_t exp_mem [NUM_IQ][64];
    logic [5:0] exp_rd [NUM_IQ];
    logic [5:0] exp_wr [NUM_IQ];
    int exp_cnt [NUM_IQ];
    int errors;
    int checks;
    int pops;
    int timeouts;

    dispatch_top #(.IQ_DEPTH(IQ_DEPTH)) dispatch_top_inst (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic report_error(input string msg);
        errors++;
        $display("Error at time %0t: %s", $time, msg);
    endtask

    task automatic note_timeout(input string what);
        timeouts++;
        $display("Timeout at time %0t while waiting for %s", $time, what);
    endtask

    task automatic clear_refs();
        for (int q = 0; q < NUM_IQ; q++) begin
            exp_rd[q] = '0;
            exp_wr[q] = '0;
            exp_cnt[q] = 0;
        end
    endtask

    function automatic rename_bundle_t random_bundle();
        rename_bundle_t b;
        b.valid = 2'($urandom);
        for (int i = 0; i < DISPATCH_WIDTH; i++) begin
            b.pc[i] = $urandom;
            b.areg[i] = 5'($urandom);
            b.preg[i] = 6'($urandom);
            b.w_reg[i] = 1'($urandom);
            b.w_mem[i] = 1'($urandom);
            b.fu[i] = fu_sel_t'($urandom % 3);
            b.imm[i] = $urandom;
        end
        for (int k = 0; k < NUM_SRC; k++) begin
            b.src_preg[k] = 6'($urandom);
            b.arf_data[k] = $urandom;
        end
        b.use_imm = 4'($urandom);
        // rename data only now and then so bypass and rob paths get used
        b.rename_data_valid = 4'($urandom & $urandom);
        return b;
    endfunction

    function automatic rename_bundle_t mdu_bundle();
        rename_bundle_t b;
        b = random_bundle();
        b.valid = 2'b11;
        b.fu = {FU_MDU, FU_MDU};
        return b;
    endfunction

    // two cdb results never target the same preg
    function automatic cdb_pair_t random_cdb(input rename_bundle_t b);
        cdb_pair_t c;
        for (int j = 0; j < NUM_CDB; j++) begin
            c[j].we = ($urandom % 4) != 0;
            c[j].preg = ($urandom % 2) != 0 ? b.src_preg[2'($urandom)] : 6'($urandom);
            c[j].data = $urandom;
        end
        if (c[1].preg == c[0].preg) begin
            c[1].preg = c[0].preg ^ 6'd1;
        end
        return c;
    endfunction

    function automatic issue_pkt_t expect_pkt(input rename_bundle_t b, input cdb_pair_t c,
                                             input rob_words_t rd,
                                             input logic [NUM_SRC-1:0] rc, input int q);
        issue_pkt_t p;
        iq_idx_t target;
        logic hit0;
        logic hit1;
        for (int j = 0; j < DISPATCH_WIDTH; j++) begin
            target = (b.fu[j] == FU_MDU) ? IQ_MDU :
                     (b.fu[j] == FU_LSU) ? IQ_LSU :
                     (b.preg[j][0] ? IQ_ALU1 : IQ_ALU0);
            p.choose[j] = b.valid[j] && (target == iq_idx_t'(q));
        end
        for (int k = 0; k < NUM_SRC; k++) begin
            hit0 = c[0].we && (c[0].preg == b.src_preg[k]);
            hit1 = c[1].we && (c[1].preg == b.src_preg[k]);
            if (b.rename_data_valid[k]) begin
                p.data[k] = b.use_imm[k] ? b.imm[k / 2] : b.arf_data[k];
            end else begin
                p.data[k] = hit0 ? c[0].data : (hit1 ? c[1].data : rd[k]);
            end
            p.data_valid[k] = b.rename_data_valid[k] | hit0 | hit1 | rc[k];
        end
        p.src_preg = b.src_preg;
        p.fu = b.fu;
        p.preg = b.preg;
        return p;
    endfunction

    function automatic rob_entry_t expect_rob(input rename_bundle_t b, input int i);
        rob_entry_t e;
        e.valid = b.valid[i];
        e.pc = b.pc[i];
        e.areg = b.areg[i];
        e.preg = b.preg[i];
        e.src_preg[0] = b.src_preg[2 * i];
        e.src_preg[1] = b.src_preg[2 * i + 1];
        e.w_reg = b.w_reg[i];
        e.w_mem = b.w_mem[i];
        return e;
    endfunction

    // pops checked against the model and acceptances extend it
    always @(posedge clk) begin
        issue_pkt_t exp_pkt;
        if (!rst_n_i) begin
            clear_refs();
        end else begin
            for (int q = 0; q < NUM_IQ; q++) begin
                if (iss_valid_o[q] && iss_ready_i[q]) begin
                    if (exp_cnt[q] == 0) begin
                        report_error($sformatf("queue %0d issued an unexpected packet", q));
                    end else begin
                        checks++;
                        pops++;
                        assert (iss_pkt_o[q] == exp_mem[q][exp_rd[q]])
                            else report_error($sformatf("queue %0d packet %h, expected %h",
                                q, iss_pkt_o[q], exp_mem[q][exp_rd[q]]));
                        exp_rd[q] = exp_rd[q] + 1'b1;
                        exp_cnt[q]--;
                    end
                end
            end
            if (flush_i) begin
                clear_refs();
            end else if (rn_valid_i && rn_ready_o) begin
                checks++;
                assert (rob_we_o == rn_bundle_i.valid)
                    else report_error($sformatf("rob_we_o %b, expected %b",
                        rob_we_o, rn_bundle_i.valid));
                for (int i = 0; i < DISPATCH_WIDTH; i++) begin
                    assert (rob_entry_o[i] == expect_rob(rn_bundle_i, i))
                        else report_error($sformatf("rob_entry_o[%0d] %h, expected %h",
                            i, rob_entry_o[i], expect_rob(rn_bundle_i, i)));
                end
                for (int q = 0; q < NUM_IQ; q++) begin
                    exp_pkt = expect_pkt(rn_bundle_i, cdb_i, rob_data_i, rob_complete_i, q);
                    if (exp_pkt.choose != '0) begin
                        exp_mem[q][exp_wr[q]] = exp_pkt;
                        exp_wr[q] = exp_wr[q] + 1'b1;
                        exp_cnt[q]++;
                    end
                    assert (exp_cnt[q] <= IQ_DEPTH)
                        else report_error($sformatf("queue %0d holds %0d packets, depth %0d",
                            q, exp_cnt[q], IQ_DEPTH));
                end
            end
        end
    end

    a_rob_idle : assert property (@(posedge clk) disable iff (!rst_n_i)
        !(rn_valid_i && rn_ready_o) |-> (rob_we_o == '0))
        else report_error("rob_we_o set without an accepted bundle");

    a_flush_ready : assert property (@(posedge clk) disable iff (!rst_n_i)
        flush_i |-> !rn_ready_o)
        else report_error("rn_ready_o high during flush");

    a_flush_empty : assert property (@(posedge clk) disable iff (!rst_n_i)
        flush_i |=> (iss_valid_o == '0))
        else report_error("iss_valid_o set in the cycle after flush");

    task automatic wait_accept(input string what);
        int n;
        bit acc;
        n = 0;
        acc = 1'b0;
        while (!acc && n < WAIT_LIMIT) begin
            @(posedge clk);
            acc = rn_valid_i && rn_ready_o;
            n++;
        end
        if (!acc) begin
            note_timeout(what);
        end
        rn_valid_i <= 1'b0;
    endtask

    task automatic send_bundle(input rename_bundle_t b, input cdb_pair_t c,
                               input logic [NUM_SRC-1:0] rc);
        @(posedge clk);
        rn_valid_i <= 1'b1;
        rn_bundle_i <= b;
        cdb_i <= c;
        rob_data_i <= {$urandom, $urandom, $urandom, $urandom};
        rob_complete_i <= rc;
        wait_accept("a directed bundle to be accepted");
    endtask

    task automatic wait_drained(input string what);
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while ((exp_cnt[0] + exp_cnt[1] + exp_cnt[2] + exp_cnt[3]) != 0
                   && n < WAIT_LIMIT);
        if (n >= WAIT_LIMIT) begin
            note_timeout(what);
        end
    endtask

    initial begin
        rename_bundle_t cur;
        cdb_pair_t c;
        logic [NUM_IQ-1:0] rdy;
        int hold [NUM_IQ];
        int n;
        void'($urandom(32'h0173217e));
        errors = 0;
        checks = 0;
        pops = 0;
        timeouts = 0;
        rst_n_i = 1'b0;
        flush_i = 1'b0;
        rn_valid_i = 1'b0;
        rn_bundle_i = '0;
        cdb_i = '0;
        rob_data_i = '0;
        rob_complete_i = '0;
        iss_ready_i = '1;
        repeat (16) @(posedge clk);
        rst_n_i <= 1'b1;
        @(negedge clk);
        assert (iss_valid_o == '0 && rob_we_o == '0 && rn_ready_o)
            else report_error("outputs not idle after reset");

        // imm and arf sources plus a hit on each cdb entry
        cur = random_bundle();
        cur.valid = 2'b11;
        cur.rename_data_valid = 4'b0011;
        cur.use_imm = 4'b0001;
        cur.src_preg[2] = 6'd10;
        cur.src_preg[3] = 6'd11;
        c = random_cdb(cur);
        c[0].we = 1'b1;
        c[0].preg = 6'd10;
        c[1].we = 1'b1;
        c[1].preg = 6'd11;
        send_bundle(cur, c, 4'b0000);
        // rob complete and incomplete
        cur = random_bundle();
        cur.valid = 2'b11;
        cur.rename_data_valid = 4'b0000;
        c = random_cdb(cur);
        c[0].we = 1'b0;
        c[1].we = 1'b0;
        send_bundle(cur, c, 4'b0101);
        wait_drained("directed packets to issue");

        // stall the mdu queue until dispatch stops accepting
        @(posedge clk);
        rdy = '1;
        rdy[IQ_MDU] = 1'b0;
        iss_ready_i <= rdy;
        rn_valid_i <= 1'b1;
        rn_bundle_i <= mdu_bundle();
        n = 0;
        do begin
            @(posedge clk);
            if (rn_ready_o) begin
                rn_bundle_i <= mdu_bundle();
            end
            n++;
        end while (rn_ready_o && n < WAIT_LIMIT);
        if (rn_ready_o) begin
            note_timeout("rn_ready_o to fall under back-pressure");
        end
        repeat (6) @(posedge clk);
        iss_ready_i <= '1;
        wait_accept("the stalled bundle after release");
        wait_drained("back-pressured packets to issue");

        // fill the queues and flush them with a bundle waiting
        @(posedge clk);
        iss_ready_i <= '0;
        repeat (3) begin
            cur = random_bundle();
            cur.valid = 2'b11;
            send_bundle(cur, random_cdb(cur), 4'($urandom));
        end
        @(posedge clk);
        cur = random_bundle();
        cur.valid = 2'b11;
        flush_i <= 1'b1;
        rn_valid_i <= 1'b1;
        rn_bundle_i <= cur;
        @(posedge clk);
        flush_i <= 1'b0;
        @(negedge clk);
        assert (iss_valid_o == '0) else report_error("queues not empty after flush");

        for (int q = 0; q < NUM_IQ; q++) begin
            hold[q] = 0;
        end
        cur = random_bundle();
        for (int cyc = 0; cyc < 400; cyc++) begin
            @(posedge clk);
            if (!rn_valid_i || rn_ready_o) begin
                cur = random_bundle();
                rn_valid_i <= ($urandom % 4) != 0;
                rn_bundle_i <= cur;
            end
            cdb_i <= random_cdb(cur);
            rob_data_i <= {$urandom, $urandom, $urandom, $urandom};
            rob_complete_i <= 4'($urandom);
            // ready held low in stretches about a third of the time
            for (int q = 0; q < NUM_IQ; q++) begin
                if (hold[q] == 0) begin
                    rdy[q] = ($urandom % 3) != 0;
                    hold[q] = 1 + ($urandom % 12);
                end
                hold[q]--;
            end
            iss_ready_i <= rdy;
        end
        @(posedge clk);
        iss_ready_i <= '1;
        if (rn_valid_i && !rn_ready_o) begin
            wait_accept("the last random bundle");
        end else begin
            rn_valid_i <= 1'b0;
        end
        wait_drained("random packets to issue");
        if (pops == 0) begin
            report_error("no packet left the issue queues");
        end

        $display("Checks: %0d, packets: %0d, errors: %0d, timeouts: %0d",
                 checks, pops, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sources.f */
hw/dispatch_pkg.sv
hw/operand_select.sv
hw/dispatch_route.sv
hw/issue_queue.sv
hw/dispatch_top.sv
verification/tb_dispatch_top.sv

/* Makefile */
TOP := tb_dispatch_top

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f sources.f

# pass only when the pass message shows up as a line of its own
sim:
	verilator --binary --assert --top-module $(TOP) -f sources.f -Mdir obj_dir
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "Simulation PASSED"

clean:
	rm -rf obj_dir
